// ==== source/mips_isa_pkg.sv ====
// MIPS32 encodings for the supported integer subset only
// Instruction words are viewed through one packed union
package mips_isa_pkg;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_form_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_form_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target;
	} j_form_t;

	typedef union packed {
		r_form_t r;
		i_form_t i;
		j_form_t j;
	} instr_t;

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0A;
	localparam logic [5:0] OP_ANDI    = 6'h0C;
	localparam logic [5:0] OP_ORI     = 6'h0D;
	localparam logic [5:0] OP_XORI    = 6'h0E;
	localparam logic [5:0] OP_LUI     = 6'h0F;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2B;

	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2A;
	localparam logic [5:0] FN_SLTU = 6'h2B;

	localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;
	localparam logic [4:0]  REG_V0       = 5'd2;
	localparam logic [31:0] HALT_ADDRESS = 32'h00000000;

endpackage

// ==== source/mips_pipe_pkg.sv ====
// Internal pipeline encodings, not visible on the bus
package mips_pipe_pkg;

	localparam int WORD_W = 32;
	localparam int REG_AW = 5;

	localparam logic [3:0] ALU_ADD  = 4'd0;
	localparam logic [3:0] ALU_SUB  = 4'd1;
	localparam logic [3:0] ALU_AND  = 4'd2;
	localparam logic [3:0] ALU_OR   = 4'd3;
	localparam logic [3:0] ALU_XOR  = 4'd4;
	localparam logic [3:0] ALU_SLT  = 4'd5;
	localparam logic [3:0] ALU_SLTU = 4'd6;
	localparam logic [3:0] ALU_SLL  = 4'd7;
	localparam logic [3:0] ALU_SRL  = 4'd8;
	localparam logic [3:0] ALU_LUI  = 4'd9;

	localparam logic [1:0] FWD_REG = 2'd0;
	localparam logic [1:0] FWD_MEM = 2'd1;
	localparam logic [1:0] FWD_WB  = 2'd2;

endpackage

// ==== source/mips_fetch.sv ====
// PC and fetch/decode register, both frozen while stalled
// Branch and jump targets arrive from decode, so the next fetch is the delay slot
`timescale 1ns/1ns
module mips_fetch (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              advance,
	input  logic                              stall,
	input  logic                              take_target,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  target,
	input  mips_isa_pkg::instr_t              fetched_instr,
	output logic [mips_pipe_pkg::WORD_W-1:0]  pc,
	output mips_isa_pkg::instr_t              dec_instr,
	output logic [mips_pipe_pkg::WORD_W-1:0]  dec_pc_plus4
);
	logic [mips_pipe_pkg::WORD_W-1:0] pc_plus4;

	assign pc_plus4 = pc + 'd4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= mips_isa_pkg::RESET_VECTOR;
			dec_instr <= '0; // sll $0,$0,0
			dec_pc_plus4 <= '0;
		end else if (advance && !stall) begin
			pc <= take_target ? target : pc_plus4;
			dec_instr <= fetched_instr;
			dec_pc_plus4 <= pc_plus4;
		end
	end

endmodule

// ==== source/mips_register_file.sv ====
// 32 x 32 register file, $0 hard wired to zero
// Writeback value is visible to decode in the same step
`timescale 1ns/1ns
module mips_register_file (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              advance,
	input  logic [mips_pipe_pkg::REG_AW-1:0]  rs,
	input  logic [mips_pipe_pkg::REG_AW-1:0]  rt,
	input  logic [mips_pipe_pkg::REG_AW-1:0]  wb_dest,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  wb_value,
	input  logic                              wb_reg_write,
	output logic [mips_pipe_pkg::WORD_W-1:0]  rs_value,
	output logic [mips_pipe_pkg::WORD_W-1:0]  rt_value,
	output logic [mips_pipe_pkg::WORD_W-1:0]  register_v0
);
	logic [mips_pipe_pkg::WORD_W-1:0] regs [32];
	logic                             wb_live;

	assign wb_live = wb_reg_write && wb_dest != '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int n = 0; n < 32; n++) regs[n] <= '0;
		end else if (advance && wb_live) begin
			regs[wb_dest] <= wb_value;
		end
	end

	// Write-through
	assign rs_value = (wb_live && wb_dest == rs) ? wb_value : regs[rs];
	assign rt_value = (wb_live && wb_dest == rt) ? wb_value : regs[rt];
	assign register_v0 = regs[mips_isa_pkg::REG_V0];

endmodule

// ==== source/mips_decode.sv ====
// Decode stage, branches resolve here with one delay slot
// Unknown opcodes decode as NOPs
`timescale 1ns/1ns
module mips_decode (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              advance,
	input  logic                              stall,
	input  mips_isa_pkg::instr_t              dec_instr,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  dec_pc_plus4,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  mem_result,
	input  logic                              fwd_rs_mem,
	input  logic                              fwd_rt_mem,
	input  logic [mips_pipe_pkg::REG_AW-1:0]  wb_dest,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  wb_value,
	input  logic                              wb_reg_write,
	output logic                              take_target,
	output logic [mips_pipe_pkg::WORD_W-1:0]  target,
	output logic [mips_pipe_pkg::REG_AW-1:0]  rs,
	output logic [mips_pipe_pkg::REG_AW-1:0]  rt,
	output logic                              dec_uses_branch,
	output logic [mips_pipe_pkg::WORD_W-1:0]  register_v0,
	output logic [3:0]                        ex_alu_op,
	output logic                              ex_use_imm,
	output logic                              ex_load,
	output logic                              ex_store,
	output logic                              ex_reg_write,
	output logic                              ex_halt,
	output logic [mips_pipe_pkg::REG_AW-1:0]  ex_dest,
	output logic [mips_pipe_pkg::REG_AW-1:0]  ex_rs,
	output logic [mips_pipe_pkg::REG_AW-1:0]  ex_rt,
	output logic [mips_pipe_pkg::WORD_W-1:0]  ex_a,
	output logic [mips_pipe_pkg::WORD_W-1:0]  ex_b,
	output logic [mips_pipe_pkg::WORD_W-1:0]  ex_imm
);
	logic [mips_pipe_pkg::WORD_W-1:0] rs_value, rt_value, cmp_a, cmp_b, imm, sext;
	logic [mips_pipe_pkg::REG_AW-1:0] dest;
	logic [3:0] alu_op;
	logic use_imm, is_load, is_store, reg_write, is_beq, is_bne, is_j, is_jr, halt;

	assign rs = dec_instr.r.rs;
	assign rt = dec_instr.r.rt;
	assign sext = {{16{dec_instr.i.imm[15]}}, dec_instr.i.imm};

	mips_register_file u_regs (
		.clk(clk), .rst_n(rst_n), .advance(advance),
		.rs(rs), .rt(rt),
		.wb_dest(wb_dest), .wb_value(wb_value), .wb_reg_write(wb_reg_write),
		.rs_value(rs_value), .rt_value(rt_value), .register_v0(register_v0)
	);

	always_comb begin
		alu_op = mips_pipe_pkg::ALU_ADD;
		use_imm = 1'b1;
		is_load = 1'b0;
		is_store = 1'b0;
		reg_write = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_j = 1'b0;
		is_jr = 1'b0;
		dest = dec_instr.i.rt;
		imm = sext;
		case (dec_instr.r.op)
			mips_isa_pkg::OP_SPECIAL: begin
				use_imm = 1'b0;
				reg_write = 1'b1;
				dest = dec_instr.r.rd;
				imm = {27'b0, dec_instr.r.shamt}; // Shift amount
				case (dec_instr.r.funct)
					mips_isa_pkg::FN_ADDU: alu_op = mips_pipe_pkg::ALU_ADD;
					mips_isa_pkg::FN_SUBU: alu_op = mips_pipe_pkg::ALU_SUB;
					mips_isa_pkg::FN_AND:  alu_op = mips_pipe_pkg::ALU_AND;
					mips_isa_pkg::FN_OR:   alu_op = mips_pipe_pkg::ALU_OR;
					mips_isa_pkg::FN_XOR:  alu_op = mips_pipe_pkg::ALU_XOR;
					mips_isa_pkg::FN_SLT:  alu_op = mips_pipe_pkg::ALU_SLT;
					mips_isa_pkg::FN_SLTU: alu_op = mips_pipe_pkg::ALU_SLTU;
					mips_isa_pkg::FN_SLL:  alu_op = mips_pipe_pkg::ALU_SLL;
					mips_isa_pkg::FN_SRL:  alu_op = mips_pipe_pkg::ALU_SRL;
					mips_isa_pkg::FN_JR: begin
						is_jr = 1'b1;
						reg_write = 1'b0;
					end
					default: reg_write = 1'b0;
				endcase
			end
			mips_isa_pkg::OP_ADDIU: reg_write = 1'b1;
			mips_isa_pkg::OP_SLTI: begin
				alu_op = mips_pipe_pkg::ALU_SLT;
				reg_write = 1'b1;
			end
			mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI: begin
				imm = {16'b0, dec_instr.i.imm}; // Logical ops zero extend
				reg_write = 1'b1;
				if (dec_instr.i.op == mips_isa_pkg::OP_ANDI)
					alu_op = mips_pipe_pkg::ALU_AND;
				else if (dec_instr.i.op == mips_isa_pkg::OP_ORI)
					alu_op = mips_pipe_pkg::ALU_OR;
				else
					alu_op = mips_pipe_pkg::ALU_XOR;
			end
			mips_isa_pkg::OP_LUI: begin
				alu_op = mips_pipe_pkg::ALU_LUI;
				reg_write = 1'b1;
			end
			mips_isa_pkg::OP_LW: begin
				is_load = 1'b1;
				reg_write = 1'b1;
			end
			mips_isa_pkg::OP_SW:  is_store = 1'b1;
			mips_isa_pkg::OP_BEQ: is_beq = 1'b1;
			mips_isa_pkg::OP_BNE: is_bne = 1'b1;
			mips_isa_pkg::OP_J:   is_j = 1'b1;
			default: ;
		endcase
	end

	// Compare operands, only the memory stage forwards here
	assign cmp_a = fwd_rs_mem ? mem_result : rs_value;
	assign cmp_b = fwd_rt_mem ? mem_result : rt_value;
	assign dec_uses_branch = is_beq || is_bne || is_jr;
	assign take_target = (is_beq && cmp_a == cmp_b) || (is_bne && cmp_a != cmp_b)
		|| is_j || is_jr;
	assign halt = is_jr && cmp_a == mips_isa_pkg::HALT_ADDRESS;

	always_comb begin
		if (is_jr)
			target = cmp_a;
		else if (is_j)
			target = {dec_pc_plus4[31:28], dec_instr.j.target, 2'b00};
		else
			target = dec_pc_plus4 + {sext[29:0], 2'b00};
	end

	// Stall turns the slot into a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_alu_op <= mips_pipe_pkg::ALU_ADD;
			ex_use_imm <= 1'b0;
			ex_load <= 1'b0;
			ex_store <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_halt <= 1'b0;
		end else if (advance) begin
			ex_alu_op <= alu_op;
			ex_use_imm <= use_imm;
			ex_load <= is_load && !stall;
			ex_store <= is_store && !stall;
			ex_reg_write <= reg_write && !stall;
			ex_halt <= halt && !stall;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			ex_dest <= dest;
			ex_rs <= rs;
			ex_rt <= rt;
			ex_a <= rs_value;
			ex_b <= rt_value;
			ex_imm <= imm;
		end
	end

endmodule

// ==== source/mips_execute.sv ====
// Execute stage with forwarding from memory and writeback
// Shifts take their amount from the low five bits of ex_imm
`timescale 1ns/1ns
module mips_execute (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              advance,
	input  logic [3:0]                        ex_alu_op,
	input  logic                              ex_use_imm,
	input  logic                              ex_load,
	input  logic                              ex_store,
	input  logic                              ex_reg_write,
	input  logic                              ex_halt,
	input  logic [mips_pipe_pkg::REG_AW-1:0]  ex_dest,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  ex_a,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  ex_b,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  ex_imm,
	input  logic [1:0]                        fwd_a,
	input  logic [1:0]                        fwd_b,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  wb_value,
	output logic [mips_pipe_pkg::WORD_W-1:0]  mem_result,
	output logic [mips_pipe_pkg::WORD_W-1:0]  mem_store_data,
	output logic [mips_pipe_pkg::REG_AW-1:0]  mem_dest,
	output logic                              mem_load,
	output logic                              mem_store,
	output logic                              mem_reg_write,
	output logic                              mem_halt
);
	logic [mips_pipe_pkg::WORD_W-1:0] op_a, op_b, alu_b, result;

	always_comb begin
		case (fwd_a)
			mips_pipe_pkg::FWD_MEM: op_a = mem_result;
			mips_pipe_pkg::FWD_WB:  op_a = wb_value;
			default:                op_a = ex_a;
		endcase
		case (fwd_b)
			mips_pipe_pkg::FWD_MEM: op_b = mem_result;
			mips_pipe_pkg::FWD_WB:  op_b = wb_value;
			default:                op_b = ex_b;
		endcase
	end

	assign alu_b = ex_use_imm ? ex_imm : op_b;

	always_comb begin
		result = '0;
		case (ex_alu_op)
			mips_pipe_pkg::ALU_ADD:  result = op_a + alu_b;
			mips_pipe_pkg::ALU_SUB:  result = op_a - alu_b;
			mips_pipe_pkg::ALU_AND:  result = op_a & alu_b;
			mips_pipe_pkg::ALU_OR:   result = op_a | alu_b;
			mips_pipe_pkg::ALU_XOR:  result = op_a ^ alu_b;
			mips_pipe_pkg::ALU_SLT:  result[0] = $signed(op_a) < $signed(alu_b);
			mips_pipe_pkg::ALU_SLTU: result[0] = op_a < alu_b;
			mips_pipe_pkg::ALU_SLL:  result = op_b << ex_imm[4:0];
			mips_pipe_pkg::ALU_SRL:  result = op_b >> ex_imm[4:0];
			mips_pipe_pkg::ALU_LUI:  result = {alu_b[15:0], 16'b0};
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_load <= 1'b0;
			mem_store <= 1'b0;
			mem_reg_write <= 1'b0;
			mem_halt <= 1'b0;
		end else if (advance) begin
			mem_load <= ex_load;
			mem_store <= ex_store;
			mem_reg_write <= ex_reg_write;
			mem_halt <= ex_halt;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			mem_result <= result;
			mem_store_data <= op_b; // Forwarded rt
			mem_dest <= ex_dest;
		end
	end

endmodule

// ==== source/mips_hazard.sv ====
// Forwarding selects and stall decisions, purely combinational
// Register $0 is never forwarded
`timescale 1ns/1ns
module mips_hazard (
	input  logic [mips_pipe_pkg::REG_AW-1:0] rs,
	input  logic [mips_pipe_pkg::REG_AW-1:0] rt,
	input  logic                             dec_uses_branch,
	input  logic [mips_pipe_pkg::REG_AW-1:0] ex_rs,
	input  logic [mips_pipe_pkg::REG_AW-1:0] ex_rt,
	input  logic [mips_pipe_pkg::REG_AW-1:0] ex_dest,
	input  logic                             ex_load,
	input  logic                             ex_reg_write,
	input  logic [mips_pipe_pkg::REG_AW-1:0] mem_dest,
	input  logic                             mem_load,
	input  logic                             mem_reg_write,
	input  logic [mips_pipe_pkg::REG_AW-1:0] wb_dest,
	input  logic                             wb_reg_write,
	output logic                             stall,
	output logic [1:0]                       fwd_a,
	output logic [1:0]                       fwd_b,
	output logic                             fwd_rs_mem,
	output logic                             fwd_rt_mem
);
	logic ex_hits, mem_load_hits;

	function automatic logic [1:0] pick(input logic [mips_pipe_pkg::REG_AW-1:0] src);
		if (src == '0)
			pick = mips_pipe_pkg::FWD_REG;
		else if (mem_reg_write && mem_dest == src)
			pick = mips_pipe_pkg::FWD_MEM; // Nearest writer wins
		else if (wb_reg_write && wb_dest == src)
			pick = mips_pipe_pkg::FWD_WB;
		else
			pick = mips_pipe_pkg::FWD_REG;
	endfunction

	always_comb begin
		fwd_a = pick(ex_rs);
		fwd_b = pick(ex_rt);
	end

	assign fwd_rs_mem = mem_reg_write && mem_dest != '0 && mem_dest == rs;
	assign fwd_rt_mem = mem_reg_write && mem_dest != '0 && mem_dest == rt;

	assign ex_hits = ex_reg_write && ex_dest != '0 && (ex_dest == rs || ex_dest == rt);
	assign mem_load_hits = mem_load && mem_dest != '0 && (mem_dest == rs || mem_dest == rt);
	assign stall = (ex_load && ex_hits) || (dec_uses_branch && (ex_hits || mem_load_hits));

endmodule

// ==== source/mips_bus_sequencer.sv ====
// One instruction read per step, then the data word for LW or SW
// Bus stays idle in the first cycle after reset and after halt
`timescale 1ns/1ns
module mips_bus_sequencer (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              waitrequest,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  readdata,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  pc,
	input  logic                              mem_load,
	input  logic                              mem_store,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  mem_result,
	input  logic [mips_pipe_pkg::WORD_W-1:0]  mem_store_data,
	input  logic [mips_pipe_pkg::REG_AW-1:0]  mem_dest,
	input  logic                              mem_reg_write,
	input  logic                              mem_halt,
	output logic [mips_pipe_pkg::WORD_W-1:0]  address,
	output logic                              read,
	output logic                              write,
	output logic [mips_pipe_pkg::WORD_W-1:0]  writedata,
	output logic                              advance,
	output mips_isa_pkg::instr_t              fetched_instr,
	output logic [mips_pipe_pkg::WORD_W-1:0]  wb_value,
	output logic [mips_pipe_pkg::REG_AW-1:0]  wb_dest,
	output logic                              wb_reg_write,
	output logic                              active
);
	logic running, data_phase, done, need_data;
	mips_isa_pkg::instr_t instr_q; // Word held across the data access

	assign need_data = mem_load || mem_store;
	assign read = running && active && (!data_phase || mem_load);
	assign write = running && active && data_phase && mem_store;
	assign address = data_phase ? mem_result : pc;
	assign writedata = mem_store_data;
	assign done = (read || write) && !waitrequest;
	assign advance = done && (data_phase || !need_data);
	assign fetched_instr = data_phase ? instr_q : mips_isa_pkg::instr_t'(readdata);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			data_phase <= 1'b0;
			wb_reg_write <= 1'b0;
			active <= 1'b1;
		end else begin
			running <= 1'b1;
			if (done)
				data_phase <= !data_phase && need_data;
			if (advance) begin
				wb_reg_write <= mem_reg_write;
				if (mem_halt) active <= 1'b0; // JR $0 enters writeback
			end
		end
	end

	always_ff @(posedge clk) begin
		if (done && !data_phase) instr_q <= readdata;
		if (advance) begin
			wb_value <= mem_load ? readdata : mem_result;
			wb_dest <= mem_dest;
		end
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n) !(read && write));
	a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(read || write) |-> address[1:0] == 2'b00);

endmodule

// ==== source/mips_cpu_bus.sv ====
// Five-stage MIPS32 core on one Avalon master port, word accesses only
// active falls when JR to address zero reaches writeback
`timescale 1ns/1ns
module mips_cpu_bus (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        waitrequest,
	input  logic [31:0] readdata,
	output logic        active,
	output logic [31:0] register_v0,
	output logic [31:0] address,
	output logic        read,
	output logic        write,
	output logic [31:0] writedata
);
	logic [31:0] pc, target, dec_pc_plus4, ex_a, ex_b, ex_imm;
	logic [31:0] mem_result, mem_store_data, wb_value;
	logic [4:0]  rs, rt, ex_dest, ex_rs, ex_rt, mem_dest, wb_dest;
	logic [3:0]  ex_alu_op;
	logic [1:0]  fwd_a, fwd_b;
	logic advance, stall, take_target, dec_uses_branch, fwd_rs_mem, fwd_rt_mem;
	logic ex_use_imm, ex_load, ex_store, ex_reg_write, ex_halt;
	logic mem_load, mem_store, mem_reg_write, mem_halt, wb_reg_write;
	mips_isa_pkg::instr_t fetched_instr, dec_instr;

	mips_fetch u_fetch (
		.clk(clk), .rst_n(rst_n), .advance(advance), .stall(stall),
		.take_target(take_target), .target(target), .fetched_instr(fetched_instr),
		.pc(pc), .dec_instr(dec_instr), .dec_pc_plus4(dec_pc_plus4)
	);

	mips_decode u_decode (
		.clk(clk), .rst_n(rst_n), .advance(advance), .stall(stall),
		.dec_instr(dec_instr), .dec_pc_plus4(dec_pc_plus4), .mem_result(mem_result),
		.fwd_rs_mem(fwd_rs_mem), .fwd_rt_mem(fwd_rt_mem),
		.wb_dest(wb_dest), .wb_value(wb_value), .wb_reg_write(wb_reg_write),
		.take_target(take_target), .target(target), .rs(rs), .rt(rt),
		.dec_uses_branch(dec_uses_branch), .register_v0(register_v0),
		.ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_load(ex_load),
		.ex_store(ex_store), .ex_reg_write(ex_reg_write), .ex_halt(ex_halt),
		.ex_dest(ex_dest), .ex_rs(ex_rs), .ex_rt(ex_rt),
		.ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm)
	);

	mips_hazard u_hazard (
		.rs(rs), .rt(rt), .dec_uses_branch(dec_uses_branch),
		.ex_rs(ex_rs), .ex_rt(ex_rt), .ex_dest(ex_dest),
		.ex_load(ex_load), .ex_reg_write(ex_reg_write),
		.mem_dest(mem_dest), .mem_load(mem_load), .mem_reg_write(mem_reg_write),
		.wb_dest(wb_dest), .wb_reg_write(wb_reg_write),
		.stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.fwd_rs_mem(fwd_rs_mem), .fwd_rt_mem(fwd_rt_mem)
	);

	mips_execute u_execute (
		.clk(clk), .rst_n(rst_n), .advance(advance),
		.ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_load(ex_load),
		.ex_store(ex_store), .ex_reg_write(ex_reg_write), .ex_halt(ex_halt),
		.ex_dest(ex_dest), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .wb_value(wb_value),
		.mem_result(mem_result), .mem_store_data(mem_store_data), .mem_dest(mem_dest),
		.mem_load(mem_load), .mem_store(mem_store),
		.mem_reg_write(mem_reg_write), .mem_halt(mem_halt)
	);

	mips_bus_sequencer u_seq (
		.clk(clk), .rst_n(rst_n), .waitrequest(waitrequest), .readdata(readdata),
		.pc(pc), .mem_load(mem_load), .mem_store(mem_store),
		.mem_result(mem_result), .mem_store_data(mem_store_data), .mem_dest(mem_dest),
		.mem_reg_write(mem_reg_write), .mem_halt(mem_halt),
		.address(address), .read(read), .write(write), .writedata(writedata),
		.advance(advance), .fetched_instr(fetched_instr),
		.wb_value(wb_value), .wb_dest(wb_dest), .wb_reg_write(wb_reg_write),
		.active(active)
	);

endmodule

// ==== test/avalon_memory.sv ====
// Word-only Avalon slave, code window at the reset vector, data window at 0x1000
// Reads outside both windows return zero and writes there are dropped
// waitrequest is pseudo random, high in about one cycle of three
`timescale 1ns/1ns
module avalon_memory (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] address,
	input  logic        read,
	input  logic        write,
	input  logic [31:0] writedata,
	output logic [31:0] readdata,
	output logic        waitrequest
);
	localparam logic [31:0] CODE_BASE  = 32'hBFC00000;
	localparam logic [31:0] CODE_BYTES = 32'd256;
	localparam logic [31:0] DATA_BASE  = 32'h00001000;
	localparam logic [31:0] DATA_BYTES = 32'd64;
	localparam int          IMAGE_WORDS = 128;
	localparam logic [31:0] SEED = 32'h163c_19e9;

	logic [31:0] image [IMAGE_WORDS];
	logic [31:0] rng_state;
	logic [31:0] code_off;
	logic [31:0] data_off;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		for (int n = 0; n < IMAGE_WORDS; n++)
			image[7'(n)] = '0;
		$readmemh("test/cpu_stimulus.mem", image);
	end

	assign code_off = address - CODE_BASE;
	assign data_off = address - DATA_BASE;

	always_comb begin
		if (code_off < CODE_BYTES)
			readdata = image[{1'b0, code_off[7:2]}];
		else if (data_off < DATA_BYTES)
			readdata = image[{3'b100, data_off[5:2]}]; // Data words start at 64
		else
			readdata = '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rng_state <= SEED;
			waitrequest <= 1'b0;
		end else begin
			rng_state <= xorshift(rng_state);
			waitrequest <= (xorshift(rng_state) % 32'd3) == 32'd0;
		end
	end

	// Completed writes land in the data window
	always @(posedge clk) begin
		if (rst_n && write && !waitrequest) begin
			if (data_off < DATA_BYTES)
				image[{3'b100, data_off[5:2]}] <= writedata;
		end
	end

endmodule

// ==== test/mips_cpu_tb.sv ====
// Runs the program image, checks every $2 change and every store in order
// Expected values come from the stimulus file, the run ends when active falls
`timescale 1ns/1ns
module mips_cpu_tb;
	localparam int          IMAGE_WORDS  = 128;
	localparam int          CODE_WORDS   = 64;
	localparam int          V0_BASE      = 80;
	localparam int          STORE_BASE   = 96;
	localparam int          WAIT_FACTOR  = 3;
	localparam int          CYCLE_LIMIT  = 40 * CODE_WORDS * WAIT_FACTOR;
	localparam int          DRAIN_CYCLES = 20;
	localparam logic [31:0] RESET_ADDRESS = 32'hBFC00000;

	logic        clk;
	logic        rst_n;
	logic        waitrequest;
	logic        read;
	logic        write;
	logic        active;
	logic [31:0] readdata;
	logic [31:0] address;
	logic [31:0] writedata;
	logic [31:0] register_v0;
	logic [31:0] expect_words [IMAGE_WORDS];
	logic [31:0] last_v0;
	logic        first_access_done;
	int          v0_total;
	int          v0_seen;
	int          store_total;
	int          store_seen;
	int          cycle;

	mips_cpu_bus uut (
		.clk(clk), .rst_n(rst_n), .waitrequest(waitrequest), .readdata(readdata),
		.active(active), .register_v0(register_v0), .address(address),
		.read(read), .write(write), .writedata(writedata)
	);

	avalon_memory memory (
		.clk(clk), .rst_n(rst_n), .address(address), .read(read), .write(write),
		.writedata(writedata), .readdata(readdata), .waitrequest(waitrequest)
	);

	always #2 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_v0();
		logic [31:0] expected;
		assert (v0_seen < v0_total)
			else fail_run("register_v0 changed more often than expected");
		expected = expect_words[7'(V0_BASE + 1 + v0_seen)];
		assert (register_v0 == expected)
			else fail_run($sformatf("Error at %0t: register_v0 is %h, expected %h",
				$time, register_v0, expected));
		v0_seen++;
		last_v0 = register_v0;
	endtask

	task automatic check_store();
		logic [31:0] exp_address;
		logic [31:0] exp_data;
		assert (store_seen < store_total)
			else fail_run("a store reached memory that was not expected");
		exp_address = expect_words[7'(STORE_BASE + 1 + 2 * store_seen)];
		exp_data = expect_words[7'(STORE_BASE + 2 + 2 * store_seen)];
		assert (address == exp_address)
			else fail_run($sformatf("Error at %0t: address is %h, expected %h",
				$time, address, exp_address));
		assert (writedata == exp_data)
			else fail_run($sformatf("Error at %0t: writedata is %h, expected %h",
				$time, writedata, exp_data));
		store_seen++;
	endtask

	initial begin
		for (int n = 0; n < IMAGE_WORDS; n++)
			expect_words[7'(n)] = '0;
		$readmemh("test/cpu_stimulus.mem", expect_words);
		v0_total = int'(expect_words[7'(V0_BASE)]);
		store_total = int'(expect_words[7'(STORE_BASE)]);
		v0_seen = 0;
		store_seen = 0;
		cycle = 0;
		last_v0 = '0;
		first_access_done = 1'b0;
		clk = 1'b0;
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		while (active)
			@(posedge clk);
		repeat (DRAIN_CYCLES) @(posedge clk); // Bus must stay quiet
		if (v0_seen != v0_total || store_seen != store_total) begin
			fail_run($sformatf("core halted after %0d of %0d $2 values and %0d of %0d stores",
				v0_seen, v0_total, store_seen, store_total));
		end else begin
			$display("Test OK");
			$finish;
		end
	end

	// Bus and result monitor, sampled before this edge's updates
	always @(posedge clk) begin
		if (rst_n) begin
			assert (!(read && write)) else fail_run("read and write were high together");
			if (!active)
				assert (!read && !write) else fail_run("bus access after the core halted");
			if ((read || write) && !first_access_done) begin
				assert (read) else fail_run("first bus access after reset was not a read");
				assert (address == RESET_ADDRESS)
					else fail_run($sformatf("Error at %0t: address is %h, expected %h",
						$time, address, RESET_ADDRESS));
				first_access_done = 1'b1;
			end
			if (write && !waitrequest)
				check_store();
			if (register_v0 != last_v0)
				check_v0();
		end
	end

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= CYCLE_LIMIT)
			fail_run("timeout, the core did not halt within the cycle limit");
	end

endmodule

// ==== test/cpu_stimulus.mem ====
// Words 00-3F code at the reset vector, 40-4F initial data at 0x1000
// Word 50 count of $2 values then the values, word 60 store count then address/data pairs
@00
3C021234 34425678 24030FF0 00431021 // lui, ori, addiu, addu
00435024 01435026 000A5100 000A1202 // and, xor, sll, srl
00431023 00435025 0143582A 006A602B // subu, or, slt, sltu
294DFFF8 394200FF 30420F0F 000B5880 // slti, xori, andi, sll
016C7025 01CD7025 004E1021 34081000 // pack flags, base 0x1000
8D090000 AD090004 8D020008 00491021 // load then dependent store
AD02000C 24050007 10A20002 24020011 // beq not taken
14A00002 24020022 24020BAD 10420002 // bne taken, beq taken
24020033 24020BAD 0BF00025 24020044 // j
24020BAD 3C06BFC0 34C600B0 00C00008 // jr to word 44
24020055 24020BAD 24020BAD 24020BAD
AD020010 00000008 00000000          // jr $0 halts
@40
A5A50001 00000000 00000100
@50
0000000F
12340000 12345678 12346668 00000099 FFFFF0A9
FFFFFF06 00000F06 00000F0B 00000100 A5A50101
00000011 00000022 00000033 00000044 00000055
@60
00000003
00001004 A5A50001
0000100C A5A50101
00001010 00000055

// ==== sources.f ====
source/mips_isa_pkg.sv
source/mips_pipe_pkg.sv
source/mips_fetch.sv
source/mips_register_file.sv
source/mips_decode.sv
source/mips_execute.sv
source/mips_hazard.sv
source/mips_bus_sequencer.sv
source/mips_cpu_bus.sv
test/avalon_memory.sv
test/mips_cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = mips_cpu_tb
FILELIST = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf obj_dir
